//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pkt_ingress
FILELIST  = src.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src.f
verilog/pkt_pkg.sv
verilog/free_list.sv
verilog/ingress_writer.sv
verilog/pkt_buffer_bank.sv
verilog/pkt_reader.sv
verilog/pkt_ingress_top.sv
testbench/tb_pkt_ingress.sv

//--- testbench/pkt_stim.txt
# mode flits dst_mac ethertype empty seed, all in hex, one packet per line.
# mode 0 holds out_ready low while the packet is sent, mode 1 drives it at random.
0 1 0180c2000001 0800 5 1a2b3c4d
0 3 001122334455 86dd 0 0badf00d
0 8 ffffffffffff 0806 2 13579bdf
0 2 020000000001 8100 7 2468ace0
0 5 00aabbccddee 88cc 1 cafe0001
0 4 3c0001020304 0800 3 deadbeef
0 6 02a0b0c0d0e0 88f7 4 00c0ffee
0 7 0c0d0e0f1011 0800 6 55aa55aa
0 2 0e0e0e0e0e0e 0806 0 77777777
0 4 101112131415 86dd 5 01234567
1 8 0180c2000002 0800 0 89abcdef
1 1 222222222222 8847 6 f0e1d2c3
1 5 00deadbeef01 0800 2 31415926
1 3 5c5c5c5c5c5c 88e5 1 27182818
1 6 0a0b0c0d0e0f 0806 7 16180339

//--- testbench/tb_pkt_ingress.sv
module tb_pkt_ingress
    import pkt_pkg::*;
;

    localparam int CLK_PERIOD = 40;
    localparam int QUIET_CYCLES = 4;

    logic               clk;
    logic               rst;
    logic               eth_valid;
    logic               eth_sop;
    logic               eth_eop;
    logic [EMPTY_W-1:0] eth_empty;
    logic [DATA_W-1:0]  eth_data;
    logic               out_valid;
    logic               out_sop;
    logic               out_eop;
    logic [EMPTY_W-1:0] out_empty;
    logic [DATA_W-1:0]  out_data;
    logic [15:0]        out_ethertype;
    logic               out_ready;
    logic [CNT_W-1:0]   drop_count;

    // packets as read from the stimulus file.
    int                 pkt_mode [$];
    int                 pkt_len [$];
    logic [47:0]        pkt_mac [$];
    logic [15:0]        pkt_etype [$];
    logic [EMPTY_W-1:0] pkt_empty [$];
    logic [31:0]        pkt_seed [$];

    // scoreboard, one entry per expected egress flit.
    logic [FLIT_W-1:0]  exp_flit [$];
    logic [15:0]        exp_etype [$];

    int                 errors = 0;
    int                 ready_mode = 0;
    int                 kept_pkts = 0;
    int                 returned_pkts = 0;
    int                 accepted_flits = 0;
    int                 exp_drops = 0;
    int                 timeout_cycles = 0;
    logic               watchdog_armed = 1'b0;
    logic               hold_check = 1'b0;
    logic [DATA_W-1:0]  held_data;

    pkt_ingress_top u_pkt_ingress_top (
        .clk           (clk),
        .rst           (rst),
        .eth_valid     (eth_valid),
        .eth_sop       (eth_sop),
        .eth_eop       (eth_eop),
        .eth_empty     (eth_empty),
        .eth_data      (eth_data),
        .out_valid     (out_valid),
        .out_sop       (out_sop),
        .out_eop       (out_eop),
        .out_empty     (out_empty),
        .out_data      (out_data),
        .out_ethertype (out_ethertype),
        .out_ready     (out_ready),
        .drop_count    (drop_count)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ******************************************************************
    // stimulus
    // ******************************************************************

    function automatic logic [DATA_W-1:0] body_word(input logic [31:0] seed, input int idx);
        logic [31:0] hi;
        logic [31:0] lo;
        hi = seed ^ (32'(idx) * 32'h0101_0101);
        lo = ~seed + (32'(idx) * 32'h9e37_79b9);
        return {hi, lo};
    endfunction

    task automatic load_stimulus();
        int               fd;
        int               n;
        logic [8*256-1:0] line;
        logic [31:0]      f_mode;
        logic [31:0]      f_len;
        logic [47:0]      f_mac;
        logic [15:0]      f_etype;
        logic [31:0]      f_empty;
        logic [31:0]      f_seed;
        fd = $fopen("testbench/pkt_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file testbench/pkt_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = '0;
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%h %h %h %h %h %h",
                            f_mode, f_len, f_mac, f_etype, f_empty, f_seed);
                // comment and blank lines match no field.
                if (n == 6 && f_len >= 1 && f_len <= MAX_FLITS && f_empty < 8) begin
                    pkt_mode.push_back(int'(f_mode));
                    pkt_len.push_back(int'(f_len));
                    pkt_mac.push_back(f_mac);
                    pkt_etype.push_back(f_etype);
                    pkt_empty.push_back(f_empty[EMPTY_W-1:0]);
                    pkt_seed.push_back(f_seed);
                end else if (n > 0) begin
                    $display("skipped a malformed line in the stimulus file");
                    errors++;
                end
            end
        end
        $fclose(fd);
    endtask

    // out_ready changes only here, right after the falling edge.
    task automatic next_cycle();
        @(negedge clk);
        if (ready_mode == 2) begin
            out_ready = 1'b1;
        end else if (ready_mode == 1) begin
            out_ready = ($urandom % 4) != 0;
        end else begin
            out_ready = 1'b0;
        end
    endtask

    task automatic wait_egress_quiet();
        int quiet;
        int last;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            last = accepted_flits;
            next_cycle();
            if (accepted_flits == last) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
    endtask

    task automatic send_packet(input int idx);
        int                 len;
        logic               kept;
        logic [DATA_W-1:0]  data;
        logic [EMPTY_W-1:0] empty;
        len = pkt_len[idx];
        ready_mode = pkt_mode[idx];
        wait_egress_quiet();
        // a packet is dropped exactly when every buffer is still held at its sop.
        kept = (kept_pkts - returned_pkts) < NUM_PKTS;
        if (kept) begin
            kept_pkts++;
        end else begin
            exp_drops++;
        end
        for (int i = 0; i < len; i++) begin
            data = (i == 0) ? {pkt_mac[idx], pkt_etype[idx]} : body_word(pkt_seed[idx], i);
            empty = (i == len - 1) ? pkt_empty[idx] : '0;
            eth_valid = 1'b1;
            eth_sop = (i == 0);
            eth_eop = (i == len - 1);
            eth_empty = empty;
            eth_data = data;
            if (kept) begin
                exp_flit.push_back({eth_sop, eth_eop, empty, data});
                exp_etype.push_back(pkt_etype[idx]);
            end
            next_cycle();
        end
        eth_valid = 1'b0;
        eth_sop = 1'b0;
        eth_eop = 1'b0;
        assert (drop_count == CNT_W'(exp_drops)) else begin
            $display("FAIL drop_count expected %h actual %h", CNT_W'(exp_drops), drop_count);
            errors++;
        end
    endtask

    // ******************************************************************
    // egress monitor and scoreboard
    // ******************************************************************

    task automatic check_accepted_flit();
        logic [FLIT_W-1:0] e;
        logic [15:0]       t;
        assert (exp_flit.size() != 0) else begin
            $display("a flit left the egress with no packet outstanding, data %h", out_data);
            errors++;
        end
        if (exp_flit.size() != 0) begin
            e = exp_flit.pop_front();
            t = exp_etype.pop_front();
            assert (out_data == e[DATA_W-1:0]) else begin
                $display("FAIL out_data expected %h actual %h", e[DATA_W-1:0], out_data);
                errors++;
            end
            assert (out_sop == e[FLIT_W-1]) else begin
                $display("FAIL out_sop expected %h actual %h", e[FLIT_W-1], out_sop);
                errors++;
            end
            assert (out_eop == e[FLIT_W-2]) else begin
                $display("FAIL out_eop expected %h actual %h", e[FLIT_W-2], out_eop);
                errors++;
            end
            assert (out_empty == e[DATA_W +: EMPTY_W]) else begin
                $display("FAIL out_empty expected %h actual %h", e[DATA_W +: EMPTY_W], out_empty);
                errors++;
            end
            if (e[FLIT_W-1]) begin
                assert (out_ethertype == t) else begin
                    $display("FAIL out_ethertype expected %h actual %h", t, out_ethertype);
                    errors++;
                end
            end
        end
        accepted_flits++;
        // the DUT frees the buffer on the same edge.
        if (out_eop) begin
            returned_pkts++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (hold_check) begin
                assert (out_valid) else begin
                    $display("out_valid fell before the held flit was accepted");
                    errors++;
                end
                assert (out_data == held_data) else begin
                    $display("FAIL out_data expected %h actual %h", held_data, out_data);
                    errors++;
                end
            end
            hold_check = out_valid && !out_ready;
            held_data = out_data;
            if (out_valid && out_ready) begin
                check_accepted_flit();
            end
        end
    end

    // ******************************************************************
    // watchdog and main sequence
    // ******************************************************************

    initial begin
        wait (watchdog_armed);
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the egress never drained", timeout_cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        int total_flits;
        void'($urandom(47));
        rst = 1'b1;
        eth_valid = 1'b0;
        eth_sop = 1'b0;
        eth_eop = 1'b0;
        eth_empty = '0;
        eth_data = '0;
        out_ready = 1'b0;
        total_flits = 0;

        load_stimulus();
        foreach (pkt_len[i]) begin
            total_flits += pkt_len[i];
        end
        timeout_cycles = 20 * total_flits + 200;
        watchdog_armed = 1'b1;

        repeat (2) @(negedge clk);
        rst = 1'b0;

        foreach (pkt_len[i]) begin
            send_packet(i);
        end

        ready_mode = 2;
        while (exp_flit.size() != 0) begin
            next_cycle();
        end
        repeat (10) next_cycle();

        assert (returned_pkts == kept_pkts) else begin
            $display("%0d buffers were taken but only %0d came back", kept_pkts, returned_pkts);
            errors++;
        end

        $display("errors %0d, flits checked %0d, packets kept %0d, packets dropped %0d",
                 errors, accepted_flits, kept_pkts, exp_drops);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verilog/free_list.sv
module free_list
    import pkt_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  free_pop,
    output logic [PKT_AWIDTH-1:0] free_id,
    output logic                  free_valid,

    input  logic                  ret_valid,
    input  logic [PKT_AWIDTH-1:0] ret_id
);

    logic [PKT_AWIDTH-1:0] ids [NUM_PKTS];
    logic [PKT_AWIDTH-1:0] rd_ptr;
    logic [PKT_AWIDTH-1:0] wr_ptr;
    logic [PKT_AWIDTH:0]   count;

    logic do_pop;

    assign free_valid = (count != '0);
    assign free_id = ids[rd_ptr];
    assign do_pop = free_pop && free_valid;

    // after reset the list is full, so the write pointer wraps back onto the read pointer.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PKTS; i++) begin
                ids[i] <= PKT_AWIDTH'(i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= (PKT_AWIDTH + 1)'(NUM_PKTS);
        end else begin
            if (ret_valid) begin
                ids[wr_ptr] <= ret_id;
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // a push and a pop together leave the count alone.
            if (ret_valid && !do_pop) begin
                count <= count + 1'b1;
            end else if (!ret_valid && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- verilog/ingress_writer.sv
module ingress_writer
    import pkt_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   eth_valid,
    input  logic                   eth_sop,
    input  logic                   eth_eop,
    input  logic [EMPTY_W-1:0]     eth_empty,
    input  logic [DATA_W-1:0]      eth_data,

    input  logic [PKT_AWIDTH-1:0]  free_id,
    input  logic                   free_valid,
    output logic                   free_pop,

    output logic                   wr_en,
    output logic [BANK_SEL_W-1:0]  wr_bank,
    output logic [BANK_AWIDTH-1:0] wr_addr,
    output logic [FLIT_W-1:0]      wr_flit,

    output logic                   meta_valid,
    output logic [PKT_AWIDTH-1:0]  meta_id,
    output logic [FLIT_IDX_W:0]    meta_flits,

    output logic [CNT_W-1:0]       drop_count
);

    // state carried across the flits of one packet.
    logic [PKT_AWIDTH-1:0]  pkt_id;
    logic [FLIT_IDX_W-1:0]  flit_idx;
    logic                   drop_pkt;

    // the id, index and drop decision that apply to the flit on the input now.
    logic [PKT_AWIDTH-1:0]  id_now;
    logic [FLIT_IDX_W-1:0]  idx_now;
    logic                   drop_now;

    logic                   wr_en_r;
    logic [BANK_SEL_W-1:0]  wr_bank_r;
    logic [BANK_AWIDTH-1:0] wr_addr_r;
    logic [FLIT_W-1:0]      wr_flit_r;

    flit_word_u in_word;

    assign in_word.raw = eth_data;

    assign free_pop = eth_valid && eth_sop && free_valid;

    assign id_now = eth_sop ? free_id : pkt_id;
    assign idx_now = eth_sop ? '0 : flit_idx + 1'b1;
    assign drop_now = eth_sop ? !free_valid : drop_pkt;

    // ******************************************************************
    // first stage: buffer assignment and flit capture
    // ******************************************************************

    always_ff @(posedge clk) begin
        wr_bank_r <= id_now[BANK_SEL_W-1:0];
        wr_addr_r <= {id_now[PKT_AWIDTH-1], idx_now};
        wr_flit_r <= {eth_sop, eth_eop, eth_empty, in_word};
        meta_id <= id_now;
        meta_flits <= {1'b0, idx_now} + 1'b1;

        if (rst) begin
            // stray flits before the first sop are thrown away.
            drop_pkt <= 1'b1;
            pkt_id <= '0;
            flit_idx <= '0;
            wr_en_r <= 1'b0;
            meta_valid <= 1'b0;
            drop_count <= '0;
        end else begin
            wr_en_r <= eth_valid && !drop_now;
            meta_valid <= eth_valid && eth_eop && !drop_now;
            if (eth_valid) begin
                pkt_id <= id_now;
                flit_idx <= idx_now;
                drop_pkt <= drop_now;
                if (eth_sop && !free_valid) begin
                    drop_count <= drop_count + 1'b1;
                end
            end
        end
    end

    // second stage drives the bank write port.
    always_ff @(posedge clk) begin
        wr_bank <= wr_bank_r;
        wr_addr <= wr_addr_r;
        wr_flit <= wr_flit_r;
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= wr_en_r;
        end
    end

endmodule

//--- verilog/pkt_buffer_bank.sv
module pkt_buffer_bank
    import pkt_pkg::*;
(
    input  logic                   clk,

    input  logic                   we,
    input  logic [BANK_AWIDTH-1:0] waddr,
    input  logic [FLIT_W-1:0]      wdata,

    input  logic [BANK_AWIDTH-1:0] raddr,
    output logic [FLIT_W-1:0]      rdata
);

    // each bank holds two whole buffers of MAX_FLITS flits.
    localparam int DEPTH = (NUM_PKTS / NUM_BANKS) * MAX_FLITS;

    logic [FLIT_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read during write to the same address returns the old word.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- verilog/pkt_ingress_top.sv
module pkt_ingress_top
    import pkt_pkg::*;
(
    input  logic               clk,
    input  logic               rst,

    input  logic               eth_valid,
    input  logic               eth_sop,
    input  logic               eth_eop,
    input  logic [EMPTY_W-1:0] eth_empty,
    input  logic [DATA_W-1:0]  eth_data,

    output logic               out_valid,
    output logic               out_sop,
    output logic               out_eop,
    output logic [EMPTY_W-1:0] out_empty,
    output logic [DATA_W-1:0]  out_data,
    output logic [15:0]        out_ethertype,
    input  logic               out_ready,

    output logic [CNT_W-1:0]   drop_count
);

    logic [PKT_AWIDTH-1:0]       free_id;
    logic                        free_valid;
    logic                        free_pop;
    logic                        ret_valid;
    logic [PKT_AWIDTH-1:0]       ret_id;

    logic                        wr_en;
    logic [BANK_SEL_W-1:0]       wr_bank;
    logic [BANK_AWIDTH-1:0]      wr_addr;
    logic [FLIT_W-1:0]           wr_flit;

    logic                        meta_valid;
    logic [PKT_AWIDTH-1:0]       meta_id;
    logic [FLIT_IDX_W:0]         meta_flits;

    logic [BANK_AWIDTH-1:0]      rd_addr;
    logic [NUM_BANKS*FLIT_W-1:0] rd_bank_flits;

    free_list u_free_list (
        .clk        (clk),
        .rst        (rst),
        .free_pop   (free_pop),
        .free_id    (free_id),
        .free_valid (free_valid),
        .ret_valid  (ret_valid),
        .ret_id     (ret_id)
    );

    ingress_writer u_ingress_writer (
        .clk        (clk),
        .rst        (rst),
        .eth_valid  (eth_valid),
        .eth_sop    (eth_sop),
        .eth_eop    (eth_eop),
        .eth_empty  (eth_empty),
        .eth_data   (eth_data),
        .free_id    (free_id),
        .free_valid (free_valid),
        .free_pop   (free_pop),
        .wr_en      (wr_en),
        .wr_bank    (wr_bank),
        .wr_addr    (wr_addr),
        .wr_flit    (wr_flit),
        .meta_valid (meta_valid),
        .meta_id    (meta_id),
        .meta_flits (meta_flits),
        .drop_count (drop_count)
    );

    // every bank sees the same write and read addresses, only the write enable is decoded.
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        pkt_buffer_bank u_bank (
            .clk   (clk),
            .we    (wr_en && (wr_bank == BANK_SEL_W'(g))),
            .waddr (wr_addr),
            .wdata (wr_flit),
            .raddr (rd_addr),
            .rdata (rd_bank_flits[g*FLIT_W +: FLIT_W])
        );
    end

    pkt_reader u_pkt_reader (
        .clk           (clk),
        .rst           (rst),
        .meta_valid    (meta_valid),
        .meta_id       (meta_id),
        .meta_flits    (meta_flits),
        .rd_addr       (rd_addr),
        .rd_bank_flits (rd_bank_flits),
        .out_valid     (out_valid),
        .out_sop       (out_sop),
        .out_eop       (out_eop),
        .out_empty     (out_empty),
        .out_data      (out_data),
        .out_ethertype (out_ethertype),
        .out_ready     (out_ready),
        .ret_valid     (ret_valid),
        .ret_id        (ret_id)
    );

endmodule

//--- verilog/pkt_pkg.sv
package pkt_pkg;

    // ******************************************************************
    // flit and buffer geometry
    // ******************************************************************

    localparam int DATA_W = 64;
    localparam int EMPTY_W = 3;

    // stored flit is {sop, eop, empty, data}.
    localparam int FLIT_W = DATA_W + EMPTY_W + 2;

    localparam int PKT_AWIDTH = 3;
    localparam int NUM_PKTS = 8;
    localparam int FLIT_IDX_W = 3;
    localparam int MAX_FLITS = 8;

    // the bank is picked by the low id bits, the upper id bit goes into the address.
    localparam int NUM_BANKS = 4;
    localparam int BANK_SEL_W = 2;
    localparam int BANK_AWIDTH = 4;

    localparam int CNT_W = 8;

    // ******************************************************************
    // first flit of a packet, seen as raw data or as a header
    // ******************************************************************

    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [47:0] dst_mac;
            logic [15:0] ethertype;
        } hdr;
    } flit_word_u;

endpackage

//--- verilog/pkt_reader.sv
module pkt_reader
    import pkt_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        meta_valid,
    input  logic [PKT_AWIDTH-1:0]       meta_id,
    input  logic [FLIT_IDX_W:0]         meta_flits,

    output logic [BANK_AWIDTH-1:0]      rd_addr,
    input  logic [NUM_BANKS*FLIT_W-1:0] rd_bank_flits,

    output logic                        out_valid,
    output logic                        out_sop,
    output logic                        out_eop,
    output logic [EMPTY_W-1:0]          out_empty,
    output logic [DATA_W-1:0]           out_data,
    output logic [15:0]                 out_ethertype,
    input  logic                        out_ready,

    output logic                        ret_valid,
    output logic [PKT_AWIDTH-1:0]       ret_id
);

    logic [PKT_AWIDTH-1:0] q_id [NUM_PKTS];
    logic [FLIT_IDX_W:0]   q_flits [NUM_PKTS];
    logic [PKT_AWIDTH-1:0] q_wr;
    logic [PKT_AWIDTH-1:0] q_rd;
    logic [PKT_AWIDTH:0]   q_count;
    logic                  q_pop;

    logic                  active;
    logic [PKT_AWIDTH-1:0] cur_id;
    logic [FLIT_IDX_W:0]   cur_flits;
    logic [FLIT_IDX_W:0]   rd_idx;
    logic                  issue;

    logic                  rd_pend;
    logic [BANK_SEL_W-1:0] rd_bank_q;
    logic [PKT_AWIDTH-1:0] rd_id_q;
    logic [FLIT_W-1:0]     rd_flit_sel;

    logic                  skid_valid;
    logic [FLIT_W-1:0]     skid_flit;
    logic [PKT_AWIDTH-1:0] skid_id;

    logic [FLIT_W-1:0]     out_flit;
    logic [PKT_AWIDTH-1:0] out_id;
    logic                  accept;
    logic                  load_from_rd;
    logic                  load_out;
    logic [FLIT_W-1:0]     next_flit;
    logic [PKT_AWIDTH-1:0] next_id;
    flit_word_u            next_word;

    // ******************************************************************
    // metadata queue
    // ******************************************************************

    assign q_pop = !active && (q_count != '0);

    always_ff @(posedge clk) begin
        if (meta_valid) begin
            q_id[q_wr] <= meta_id;
            q_flits[q_wr] <= meta_flits;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr <= '0;
            q_rd <= '0;
            q_count <= '0;
        end else begin
            if (meta_valid) begin
                q_wr <= q_wr + 1'b1;
            end
            if (q_pop) begin
                q_rd <= q_rd + 1'b1;
            end
            if (meta_valid && !q_pop) begin
                q_count <= q_count + 1'b1;
            end else if (!meta_valid && q_pop) begin
                q_count <= q_count - 1'b1;
            end
        end
    end

    // ******************************************************************
    // read sequencing
    // ******************************************************************

    // a read is only issued when its data is sure to find a free register.
    assign issue = active && !skid_valid && !(rd_pend && out_valid && !out_ready);
    assign rd_addr = {cur_id[PKT_AWIDTH-1], rd_idx[FLIT_IDX_W-1:0]};
    assign rd_flit_sel = rd_bank_flits[rd_bank_q*FLIT_W +: FLIT_W];

    always_ff @(posedge clk) begin
        if (q_pop) begin
            cur_id <= q_id[q_rd];
            cur_flits <= q_flits[q_rd];
            rd_idx <= '0;
        end else if (issue) begin
            rd_idx <= rd_idx + 1'b1;
        end
        if (issue) begin
            rd_bank_q <= cur_id[BANK_SEL_W-1:0];
            rd_id_q <= cur_id;
        end

        if (rst) begin
            active <= 1'b0;
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= issue;
            if (q_pop) begin
                active <= 1'b1;
            end else if (issue && (rd_idx + 1'b1 == cur_flits)) begin
                active <= 1'b0;
            end
        end
    end

    // ******************************************************************
    // output register with skid
    // ******************************************************************

    assign accept = out_valid && out_ready;
    assign load_from_rd = rd_pend && (!out_valid || out_ready);
    assign load_out = load_from_rd || (skid_valid && out_ready);
    assign next_flit = load_from_rd ? rd_flit_sel : skid_flit;
    assign next_id = load_from_rd ? rd_id_q : skid_id;
    assign next_word = next_flit[DATA_W-1:0];

    always_ff @(posedge clk) begin
        if (rd_pend && out_valid && !out_ready) begin
            skid_flit <= rd_flit_sel;
            skid_id <= rd_id_q;
        end
        if (load_out) begin
            out_flit <= next_flit;
            out_id <= next_id;
            if (next_flit[FLIT_W-1]) begin
                out_ethertype <= next_word.hdr.ethertype;
            end
        end

        if (rst) begin
            skid_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (rd_pend && out_valid && !out_ready) begin
                skid_valid <= 1'b1;
            end else if (skid_valid && out_ready) begin
                skid_valid <= 1'b0;
            end
            if (load_out) begin
                out_valid <= 1'b1;
            end else if (accept) begin
                out_valid <= 1'b0;
            end
        end
    end

    assign out_sop = out_flit[FLIT_W-1];
    assign out_eop = out_flit[FLIT_W-2];
    assign out_empty = out_flit[DATA_W +: EMPTY_W];
    assign out_data = out_flit[DATA_W-1:0];

    // the buffer is free again once its last flit has left.
    assign ret_valid = accept && out_eop;
    assign ret_id = out_id;

endmodule
